// File: hw/palu_pkg.sv
// Word types, instruction class and subclass codes, pack widths, structs, lane helpers
`default_nettype none

package palu_pkg;

    localparam int xlen = 32;                 // Data word width

    typedef logic [xlen-1:0] word_t;
    typedef logic [3:0]      ben_t;           // Byte write enable

    // ------------------------------------------------------------------
    // Instruction fields
    // ------------------------------------------------------------------

    typedef enum logic [2:0] {
        class_parith  = 3'b001,
        class_twiddle = 3'b010,
        class_move    = 3'b101,
        class_bitwise = 3'b111
    } palu_class_e;

    // Subclass codes overlap between classes, so the class selects the meaning
    typedef logic [3:0] palu_subclass_e;

    localparam palu_subclass_e cmov    = 4'h1; // Move class
    localparam palu_subclass_e cmovn   = 4'h2;
    localparam palu_subclass_e mv2cop  = 4'h3;

    localparam palu_subclass_e lmix    = 4'h1; // Bitwise class
    localparam palu_subclass_e hmix    = 4'h2;
    localparam palu_subclass_e bop     = 4'h3;
    localparam palu_subclass_e ins     = 4'h4;
    localparam palu_subclass_e ext     = 4'h5;
    localparam palu_subclass_e lli     = 4'h6;
    localparam palu_subclass_e lui     = 4'h7;

    localparam palu_subclass_e add_px  = 4'h1; // Packed arithmetic class
    localparam palu_subclass_e sub_px  = 4'h2;
    localparam palu_subclass_e mul_px  = 4'h3;
    localparam palu_subclass_e sll_px  = 4'h4;
    localparam palu_subclass_e srl_px  = 4'h5;
    localparam palu_subclass_e rot_px  = 4'h6;
    localparam palu_subclass_e slli_px = 4'h7;
    localparam palu_subclass_e srli_px = 4'h8;
    localparam palu_subclass_e roti_px = 4'h9;

    localparam palu_subclass_e twid_b  = 4'h1; // Twiddle class
    localparam palu_subclass_e twid_n0 = 4'h2;
    localparam palu_subclass_e twid_n1 = 4'h3;
    localparam palu_subclass_e twid_c0 = 4'h4; // Low two bits pick the byte
    localparam palu_subclass_e twid_c1 = 4'h5;
    localparam palu_subclass_e twid_c2 = 4'h6;
    localparam palu_subclass_e twid_c3 = 4'h7;

    typedef enum logic [2:0] {
        pw_32 = 3'b000,
        pw_16 = 3'b001,
        pw_8  = 3'b010,
        pw_4  = 3'b011,
        pw_2  = 3'b100
    } pack_width_e;

    // ------------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------------

    typedef struct packed {
        palu_class_e    cls;
        palu_subclass_e subclass;
        pack_width_e    pw;
        word_t          imm;
    } palu_instr_t;

    typedef struct packed {
        word_t gpr_rs1;
        word_t rs1;
        word_t rs2;
        word_t rs3;
    } palu_ops_t;

    typedef struct packed {
        ben_t  ben;
        word_t wdata;
    } palu_result_t;

    // One set bit at the base of every lane
    function automatic word_t lane_mask(pack_width_e pw);
        case (pw)
            pw_16:   return 32'h0001_0001;
            pw_8:    return 32'h0101_0101;
            pw_4:    return 32'h1111_1111;
            pw_2:    return 32'h5555_5555;
            default: return 32'h0000_0001;
        endcase
    endfunction

    // Lane width in bits
    function automatic logic [5:0] lane_bits(pack_width_e pw);
        case (pw)
            pw_16:   return 6'd16;
            pw_8:    return 6'd8;
            pw_4:    return 6'd4;
            pw_2:    return 6'd2;
            default: return 6'd32;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hw/palu_adder.sv
// Packed adder and subtractor with the carry chain cut at every lane base
`default_nettype none

module palu_adder (
    input  palu_pkg::word_t       a,   // LHS
    input  palu_pkg::word_t       b,   // RHS
    input  palu_pkg::pack_width_e pw,  // Lane width
    input  logic                  sub, // Subtract instead of add
    output palu_pkg::word_t       c    // Lane-wrapped sum
);
    import palu_pkg::*;

    word_t base;   // Lane base bits
    word_t b_inv;  // RHS after optional inversion
    logic  carry;  // Ripple carry

    assign base  = lane_mask(pw);
    assign b_inv = sub ? ~b : b;

    // Ripple through the word, restarting the carry at each lane base
    always_comb begin
        carry = 1'b0;
        for (int i = 0; i < xlen; i++) begin
            if (base[i]) begin
                carry = sub;                          // +1 completes two's complement
            end
            c[i]  = a[i] ^ b_inv[i] ^ carry;
            carry = (a[i] & b_inv[i]) | (carry & (a[i] ^ b_inv[i]));
        end
    end

endmodule

`default_nettype wire

// File: hw/palu_shifter.sv
// Packed logical shift left, shift right and rotate right or left per lane
`default_nettype none

module palu_shifter (
    input  palu_pkg::word_t       a,      // Value to shift
    input  logic [4:0]            shamt,  // Shift amount
    input  palu_pkg::pack_width_e pw,     // Lane width
    input  logic                  left,   // Left, else right
    input  logic                  rotate, // Rotate, else zero fill
    output palu_pkg::word_t       c
);
    import palu_pkg::*;

    logic [5:0] lane_w;  // Bits per lane
    logic [4:0] amt;     // Amount modulo lane width
    int         pos;     // Bit position inside its lane

    assign lane_w = lane_bits(pw);
    assign amt    = shamt & 5'(lane_w - 6'd1);

    // Each result bit picks its source inside the same lane
    always_comb begin
        pos = 0;
        for (int i = 0; i < xlen; i++) begin
            pos = i & (lane_w - 1);
            if (left) begin
                if (pos >= amt) begin
                    c[i] = a[i - amt];
                end else begin
                    c[i] = rotate & a[i - amt + lane_w];   // Wraps from lane top
                end
            end else begin
                if (pos + amt < lane_w) begin
                    c[i] = a[i + amt];
                end else begin
                    c[i] = rotate & a[i + amt - lane_w];   // Wraps from lane base
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/palu_multiplier.sv
// Iterative packed shift-and-add multiplier driving the shared adder
`default_nettype none

module palu_multiplier (
    input  logic                  g_clk,
    input  logic                  rst_n,
    input  logic                  start,  // Held high while a multiply is issued
    output logic                  done,   // One cycle pulse with result valid
    input  palu_pkg::word_t       a,      // Multiplicand
    input  palu_pkg::word_t       b,      // Multiplier
    input  palu_pkg::pack_width_e pw,
    output palu_pkg::word_t       add_a,  // Shared adder LHS
    output palu_pkg::word_t       add_b,  // Shared adder RHS
    input  palu_pkg::word_t       add_c,  // Shared adder sum
    output palu_pkg::word_t       result  // Low half of each lane product
);
    import palu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_finished
    } mul_state_e;

    mul_state_e state;
    logic       start_q;    // Start seen last cycle
    logic [4:0] step;       // Current multiplier bit
    logic       last_step;
    logic [5:0] lane_w;
    word_t      base;       // Lane base bits
    word_t      acc;        // Partial products
    word_t      sa;         // Multiplicand shifted per lane
    word_t      sb;         // Multiplier, current bit at each lane base
    word_t      sel;        // Lanes taking this partial product

    assign lane_w    = lane_bits(pw);
    assign base      = lane_mask(pw);
    assign last_step = step == 5'(lane_w - 6'd1);

    // Spread each lane's current multiplier bit over the whole lane
    always_comb begin
        for (int i = 0; i < xlen; i++) begin
            sel[i] = sb[i & ~(lane_w - 1)];
        end
    end

    assign add_a  = acc;
    assign add_b  = sa & sel;
    assign result = acc;
    assign done   = state == st_finished;

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            start_q <= 1'b0;
            step    <= '0;
        end else begin
            start_q <= start;
            case (state)
                st_idle: begin
                    if (start && !start_q) begin    // Fresh start only
                        state <= st_busy;
                        step  <= '0;
                    end
                end
                st_busy: begin
                    step <= step + 5'd1;
                    if (last_step) begin
                        state <= st_finished;
                    end
                end
                default: state <= st_idle;          // Done lasts one cycle
            endcase
        end
    end

    // Datapath
    always_ff @(posedge g_clk) begin
        if (state == st_idle) begin
            acc <= '0;
            sa  <= a;
            sb  <= b;
        end else if (state == st_busy) begin
            acc <= add_c;                            // Adder wraps per lane
            sa  <= (sa << 1) & ~base;                // Drop bits leaving the lane
            sb  <= sb >> 1;
        end
    end

    // Host keeps the operands steady for the whole multiply
    a_ops_stable: assert property (@(posedge g_clk) disable iff (!rst_n)
        state == st_busy |-> $stable(a) && $stable(b));

    // Done is a single pulse and the host takes start down right after it
    a_done_pulse: assert property (@(posedge g_clk) disable iff (!rst_n)
        done |=> !done && !start);

endmodule

`default_nettype wire

// File: hw/palu_bitwise.sv
// Bit table op, field extract and insert, low and high mix, immediate loads
`default_nettype none

module palu_bitwise (
    input  palu_pkg::palu_instr_t instr,
    input  palu_pkg::word_t       rs1,
    input  palu_pkg::word_t       rs2,  // Mix mask
    input  palu_pkg::word_t       rs3,  // Destination's old value
    output palu_pkg::word_t       c
);
    import palu_pkg::*;

    logic [4:0] ei_start;   // Field start, doubled
    logic [4:0] ei_len;     // Field length, doubled
    logic [4:0] mix_ramt;   // Rotate right amount
    word_t      len_mask;
    word_t      bop_res;
    word_t      ext_res;
    word_t      ins_res;
    word_t      mix_rot;
    word_t      mix_res;

    // Table lookup with one rs1/rs2 bit pair per result bit
    always_comb begin
        for (int i = 0; i < xlen; i++) begin
            bop_res[i] = instr.imm[{rs1[i], rs2[i]}];
        end
    end

    // ------------------------------------------------------------------
    // Extract and insert
    // ------------------------------------------------------------------

    assign ei_start = {instr.imm[7:4], 1'b0};
    assign ei_len   = {instr.imm[3:0], 1'b0};
    assign len_mask = ~({xlen{1'b1}} << ei_len);

    assign ext_res  = (rs1 >> ei_start) & len_mask;
    assign ins_res  = ((rs1 & len_mask) << ei_start) | (rs3 & ~(len_mask << ei_start));

    // ------------------------------------------------------------------
    // Mix
    // ------------------------------------------------------------------

    assign mix_ramt = {instr.subclass == hmix, instr.imm[3:0]};  // hmix adds 16
    assign mix_rot  = (rs1 >> mix_ramt) | (rs1 << (6'd32 - mix_ramt));
    assign mix_res  = (rs2 & mix_rot) | (~rs2 & rs3);

    always_comb begin
        case (instr.subclass)
            lmix, hmix: c = mix_res;
            bop:        c = bop_res;
            ins:        c = ins_res;
            ext:        c = ext_res;
            lli:        c = {rs3[31:16], instr.imm[15:0]};
            lui:        c = {instr.imm[15:0], rs3[15:0]};
            default:    c = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/palu_twiddle.sv
// Byte, nibble and crumb permutes by four 2-bit lane indexes
`default_nettype none

module palu_twiddle (
    input  palu_pkg::palu_subclass_e subclass,
    input  logic [7:0]               sel,  // Top pair feeds lane 0
    input  palu_pkg::word_t          rs1,
    output palu_pkg::word_t          c
);
    import palu_pkg::*;

    logic [15:0] half;     // Halfword for twid_n0/n1
    logic [1:0]  csel;     // Byte picked by twid_cX
    logic [7:0]  byte_in;
    word_t       b_out;
    logic [15:0] n_out;
    logic [7:0]  c_out;

    assign half    = (subclass == twid_n1) ? rs1[31:16] : rs1[15:0];
    assign csel    = subclass[1:0];
    assign byte_in = rs1[8*csel +: 8];

    // Gather lane k from the index in sel
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            b_out[8*k +: 8] = rs1[8*sel[6-2*k +: 2] +: 8];
            n_out[4*k +: 4] = half[4*sel[6-2*k +: 2] +: 4];
            c_out[2*k +: 2] = byte_in[2*sel[6-2*k +: 2] +: 2];
        end
    end

    // Splice the permuted part back, rest of rs1 kept
    always_comb begin
        c = rs1;
        case (subclass)
            twid_b:  c               = b_out;
            twid_n0: c[15:0]         = n_out;
            twid_n1: c[31:16]        = n_out;
            twid_c0, twid_c1, twid_c2, twid_c3:
                     c[8*csel +: 8]  = c_out;
            default: c               = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/palu.sv
// Packed ALU top level with class decode, moves, operand steering, result mux, handshake
`default_nettype none

module palu (
    input  logic                   g_clk,
    input  logic                   rst_n,
    input  logic                   ivalid,  // Instruction presented
    output logic                   idone,   // Result valid this cycle
    input  palu_pkg::palu_instr_t  instr,
    input  palu_pkg::palu_ops_t    ops,
    output palu_pkg::palu_result_t result
);
    import palu_pkg::*;

    logic  is_move, is_bitwise, is_parith, is_twiddle;
    logic  is_add, is_sub, is_mul, is_shift;
    logic  shift_imm, shf_left, shf_rot;
    logic  move_cond, move_wen;
    logic  mul_done;
    word_t move_res, parith_res;
    word_t add_a, add_b, add_c;
    word_t mul_add_a, mul_add_b, mul_res;
    word_t shf_c, bw_c, tw_c;

    // Class decode, live only with ivalid
    assign is_move    = ivalid && instr.cls == class_move;
    assign is_bitwise = ivalid && instr.cls == class_bitwise;
    assign is_parith  = ivalid && instr.cls == class_parith;
    assign is_twiddle = ivalid && instr.cls == class_twiddle;

    // ------------------------------------------------------------------
    // Moves
    // ------------------------------------------------------------------

    assign move_cond = ops.rs2 == '0;
    assign move_res  = (instr.subclass == mv2cop) ? ops.gpr_rs1 : ops.rs1;
    assign move_wen  = is_move && ((instr.subclass == mv2cop) ||
                                   (instr.subclass == cmov  &&  move_cond) ||
                                   (instr.subclass == cmovn && !move_cond));

    // ------------------------------------------------------------------
    // Packed arithmetic
    // ------------------------------------------------------------------

    assign is_add    = is_parith && instr.subclass == add_px;
    assign is_sub    = is_parith && instr.subclass == sub_px;
    assign is_mul    = is_parith && instr.subclass == mul_px;
    assign shift_imm = is_parith && (instr.subclass inside {slli_px, srli_px, roti_px});
    assign is_shift  = shift_imm || (is_parith &&
                       (instr.subclass inside {sll_px, srl_px, rot_px}));
    assign shf_left  = instr.subclass inside {sll_px, slli_px};
    assign shf_rot   = instr.subclass inside {rot_px, roti_px};

    // Multiplier owns the adder while a multiply is in
    assign add_a = is_mul ? mul_add_a : ops.rs1;
    assign add_b = is_mul ? mul_add_b : ops.rs2;

    palu_adder u_adder (
        .a   (add_a),
        .b   (add_b),
        .pw  (instr.pw),
        .sub (is_sub),
        .c   (add_c)
    );

    palu_shifter u_shifter (
        .a      (ops.rs1),
        .shamt  (shift_imm ? instr.imm[4:0] : ops.rs2[4:0]),
        .pw     (instr.pw),
        .left   (shf_left),
        .rotate (shf_rot),
        .c      (shf_c)
    );

    palu_multiplier u_multiplier (
        .g_clk  (g_clk),
        .rst_n  (rst_n),
        .start  (is_mul),
        .done   (mul_done),
        .a      (ops.rs1),
        .b      (ops.rs2),
        .pw     (instr.pw),
        .add_a  (mul_add_a),
        .add_b  (mul_add_b),
        .add_c  (add_c),
        .result (mul_res)
    );

    assign parith_res = {xlen{is_add || is_sub}} & add_c   |
                        {xlen{is_mul}}           & mul_res |
                        {xlen{is_shift}}         & shf_c;

    // Bitwise and twiddle units decode the subclass themselves
    palu_bitwise u_bitwise (
        .instr (instr),
        .rs1   (ops.rs1),
        .rs2   (ops.rs2),
        .rs3   (ops.rs3),
        .c     (bw_c)
    );

    palu_twiddle u_twiddle (
        .subclass (instr.subclass),
        .sel      (instr.imm[7:0]),
        .rs1      (ops.rs1),
        .c        (tw_c)
    );

    // ------------------------------------------------------------------
    // Write-back and handshake
    // ------------------------------------------------------------------

    assign result.wdata = {xlen{is_move}}    & move_res   |
                          {xlen{is_bitwise}} & bw_c       |
                          {xlen{is_parith}}  & parith_res |
                          {xlen{is_twiddle}} & tw_c;

    assign result.ben   = is_move                                ? {4{move_wen}} :
                          (is_bitwise || is_parith || is_twiddle) ? 4'hf          :
                                                                    4'h0;

    assign idone = ivalid && (!is_mul || mul_done);    // Only multiply waits

    // Multiply keeps ivalid up until its done pulse
    a_mul_held: assert property (@(posedge g_clk) disable iff (!rst_n)
        $rose(is_mul) |-> ivalid throughout mul_done [->1]);

endmodule

`default_nettype wire

// File: bench/palu_tb.sv
// Testbench for palu with clock, reset, vector reader, driver, compare tasks and watchdog
`default_nettype none

module palu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import palu_pkg::*;

    // One vector line, as read from the file
    typedef struct packed {
        palu_instr_t  instr;
        palu_ops_t    ops;
        palu_result_t exp;    // Expected write-back
    } vector_t;

    logic         g_clk;
    logic         rst_n;
    logic         ivalid;
    logic         idone;
    palu_instr_t  instr;
    palu_ops_t    ops;
    palu_result_t result;

    vector_t      vecs[$];          // All vectors from the file
    bit           loaded;           // Vectors in, watchdog may start
    int           watchdog_ns;

    palu dut (
        .g_clk  (g_clk),
        .rst_n  (rst_n),
        .ivalid (ivalid),
        .idone  (idone),
        .instr  (instr),
        .ops    (ops),
        .result (result)
    );

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;  // 10 ns period
    end

    // ------------------------------------------------------------------
    // Failure handling and compares
    // ------------------------------------------------------------------

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_wdata(input word_t expected, input word_t actual, input int idx);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t vector %0d result.wdata expected %h got %h",
                     $time, idx, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_ben(input ben_t expected, input ben_t actual, input int idx);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t vector %0d result.ben expected %h got %h",
                     $time, idx, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_idone(input logic expected, input logic actual, input int idx);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t vector %0d idone expected %b got %b",
                     $time, idx, expected, actual);
            stop_with_failure();
        end
    endtask

    // ------------------------------------------------------------------
    // Vector file reader
    // ------------------------------------------------------------------

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] fld [0:9];     // cls sub pw imm gpr rs1 rs2 rs3 ben wdata
        vector_t     v;
        fd = $fopen("bench/palu_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file bench/palu_vectors.txt");
            stop_with_failure();
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() <= 1 || line.getc(0) == "#") continue;   // Blank or comment
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                        fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9]);
            if (n != 10) begin
                $display("Malformed vector line: %s", line);
                stop_with_failure();
            end
            v.instr.cls      = palu_class_e'(fld[0][2:0]);
            v.instr.subclass = palu_subclass_e'(fld[1][3:0]);
            v.instr.pw       = pack_width_e'(fld[2][2:0]);
            v.instr.imm      = fld[3];
            v.ops.gpr_rs1    = fld[4];
            v.ops.rs1        = fld[5];
            v.ops.rs2        = fld[6];
            v.ops.rs3        = fld[7];
            v.exp.ben        = fld[8][3:0];
            v.exp.wdata      = fld[9];
            vecs.push_back(v);
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            $display("No vectors found in bench/palu_vectors.txt");
            stop_with_failure();
        end
    endtask

    // Present one instruction, wait for idone, compare, then idle a while
    task automatic run_vector(input int idx);
        vector_t v;
        int      gap;
        logic    mul_op;
        v      = vecs[idx];
        mul_op = v.instr.cls == class_parith && v.instr.subclass == mul_px;
        @(posedge g_clk);
        ivalid <= 1'b1;
        instr  <= v.instr;
        ops    <= v.ops;
        @(negedge g_clk);                       // Sample away from the drive edge
        if (!mul_op) begin
            check_idone(1'b1, idone, idx);      // Zero latency outside multiply
        end
        while (!idone) @(negedge g_clk);        // Multiply takes a while
        check_ben(v.exp.ben, result.ben, idx);
        check_wdata(v.exp.wdata, result.wdata, idx);
        @(posedge g_clk);
        ivalid <= 1'b0;
        @(negedge g_clk);
        check_idone(1'b0, idone, idx);          // Idle unit stays quiet
        check_ben(4'h0, result.ben, idx);
        gap = $urandom_range(3, 0);
        repeat (gap) @(posedge g_clk);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        void'($urandom(21651));     // Fixed seed for the idle gaps
        rst_n  = 1'b0;
        ivalid = 1'b0;
        instr  = '0;
        ops    = '0;
        loaded = 1'b0;
        load_vectors();
        watchdog_ns = vecs.size() * 40 * 10 + 200;
        loaded      = 1'b1;
        repeat (2) @(posedge g_clk);
        rst_n <= 1'b1;                          // Two cycles of reset
        for (int i = 0; i < vecs.size(); i++) begin
            run_vector(i);
        end
        $display("PASS: all tests");
        $finish;
    end

    // Watchdog, sized from the vector count
    initial begin
        wait (loaded);
        #(watchdog_ns);
        $display("Timeout after %0d ns, idone never arrived", watchdog_ns);
        stop_with_failure();
    end

endmodule

`default_nettype wire

// File: palu.f
hw/palu_pkg.sv
hw/palu_adder.sv
hw/palu_shifter.sv
hw/palu_multiplier.sv
hw/palu_bitwise.sv
hw/palu_twiddle.sv
hw/palu.sv
bench/palu_tb.sv

// File: bench/palu_vectors.txt
# cls sub pw imm gpr_rs1 rs1 rs2 rs3 ben wdata, all hex, last two are expected
# cls 1 parith, 2 twiddle, 5 move, 7 bitwise; pw 0=32 1=16 2=8 3=4 4=2
5 1 0 00000000 deadbeef 12345678 00000000 00000000 f 12345678
5 1 0 00000000 deadbeef 12345678 00000001 00000000 0 12345678
5 2 0 00000000 deadbeef 12345678 00000000 00000000 0 12345678
5 2 0 00000000 deadbeef 12345678 80000000 00000000 f 12345678
5 3 0 00000000 deadbeef 12345678 00000000 00000000 f deadbeef
7 3 0 00000008 00000000 ff00ff00 f0f0f0f0 00000000 f f000f000
7 3 0 00000006 00000000 ff00ff00 f0f0f0f0 00000000 f 0ff00ff0
7 3 0 0000000e 00000000 ff00ff00 f0f0f0f0 00000000 f fff0fff0
7 5 0 00000046 00000000 12345678 00000000 00000000 f 00000456
7 4 0 00000046 00000000 12345abc 00000000 ffffffff f fffabcff
7 1 0 00000004 00000000 12345678 ffff0000 aaaaaaaa f 8123aaaa
7 2 0 00000004 00000000 12345678 ffff0000 aaaaaaaa f 4567aaaa
7 6 0 0000beef 00000000 00000000 00000000 12345678 f 1234beef
7 7 0 0000beef 00000000 00000000 00000000 12345678 f beef5678
2 1 0 000000e4 00000000 44332211 00000000 00000000 f 11223344
2 2 0 00000039 00000000 abcd4321 00000000 00000000 f abcd2341
2 3 0 00000039 00000000 4321abcd 00000000 00000000 f 2341abcd
2 4 0 000000e4 00000000 112233e4 00000000 00000000 f 1122331b
2 5 0 000000e4 00000000 1122e433 00000000 00000000 f 11221b33
2 6 0 000000e4 00000000 11e42233 00000000 00000000 f 111b2233
2 7 0 000000e4 00000000 e4112233 00000000 00000000 f 1b112233
1 1 0 00000000 00000000 ffffffff 00000002 00000000 f 00000001
1 1 1 00000000 00000000 ffff0001 00010001 00000000 f 00000002
1 1 2 00000000 00000000 ff7f0180 01810180 00000000 f 00000200
1 1 3 00000000 00000000 89abcdef 11111111 00000000 f 9abcdef0
1 1 4 00000000 00000000 e4e4e4e4 55555555 00000000 f 39393939
1 2 0 00000000 00000000 00000000 00000001 00000000 f ffffffff
1 2 1 00000000 00000000 00000005 00010006 00000000 f ffffffff
1 2 2 00000000 00000000 10203040 20101040 00000000 f f0102000
1 2 3 00000000 00000000 01234567 11111111 00000000 f f0123456
1 2 4 00000000 00000000 e4e4e4e4 55555555 00000000 f 93939393
1 4 0 00000000 00000000 12345678 00000004 00000000 f 23456780
1 9 0 00000008 00000000 12345678 ffffffff 00000000 f 78123456
1 5 1 00000000 00000000 12345678 00000014 00000000 f 01230567
1 7 1 00000004 00000000 12345678 0000001f 00000000 f 23406780
1 6 2 00000000 00000000 12345678 00000004 00000000 f 21436587
1 8 2 00000003 00000000 f0f0f0f0 00000001 00000000 f 1e1e1e1e
1 4 3 00000000 00000000 12345678 00000001 00000000 f 2468ace0
1 9 3 00000005 00000000 12345678 00000004 00000000 f 8192a3b4
1 5 4 00000000 00000000 ffffffff 00000001 00000000 f 55555555
1 7 4 00000001 00000000 55555555 00000002 00000000 f aaaaaaaa
1 3 0 00000000 00000000 00010003 00020005 00000000 f 000b000f
1 3 1 00000000 00000000 00030100 00050100 00000000 f 000f0000
1 3 2 00000000 00000000 02031011 03051010 00000000 f 060f0010
1 3 3 00000000 00000000 12345678 33333333 00000000 f 369cf258
1 3 4 00000000 00000000 e4e4e4e4 ffffffff 00000000 f 6c6c6c6c
